/* verilog/tile_defines.svh */
`ifndef TILE_DEFINES_SVH
`define TILE_DEFINES_SVH

// Datapath width
`define TILE_XLEN 32

// Architectural register file
`define TILE_NREG  16
`define TILE_REG_W $clog2(`TILE_NREG)

// Immediate field of the instruction word
`define TILE_IMM_W 12

// Reorder buffer
`define TILE_ROB_SIZE  8
`define TILE_ROB_W     $clog2(`TILE_ROB_SIZE)
`define TILE_ROB_CNT_W ($clog2(`TILE_ROB_SIZE) + 1)

// Execution lanes
`define TILE_ALU_NUM 3

// One shift-add step per multiplier bit
`define TILE_MUL_CYCLES `TILE_XLEN
`define TILE_MUL_CNT_W  $clog2(`TILE_MUL_CYCLES + 1)

`endif

/* verilog/tile_inst_pkg.sv */
`default_nettype none

`include "tile_defines.svh"

package tile_inst_pkg;

  // Opcodes of the integer tile
  typedef enum logic [2:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_AND = 3'd2,
    OP_OR  = 3'd3,
    OP_XOR = 3'd4,
    OP_MUL = 3'd5
  } op_e;

  // Second operand read as a register index
  typedef struct packed {
    logic [`TILE_REG_W-1:0]              rs2;
    logic [`TILE_IMM_W-`TILE_REG_W-1:0]  rsvd;
  } reg_opnd_t;

  // Same 12 bits, picked apart by imm_sel
  typedef union packed {
    reg_opnd_t                     r;
    logic signed [`TILE_IMM_W-1:0] imm;
  } operand_u;

  typedef struct packed {
    op_e                    op;
    logic                   imm_sel;
    logic [`TILE_REG_W-1:0] rd;
    logic [`TILE_REG_W-1:0] rs1;
    operand_u               operand;
  } inst_t;

endpackage

`default_nettype wire

/* verilog/tile_pipe_pkg.sv */
`default_nettype none

`include "tile_defines.svh"

package tile_pipe_pkg;

  // Slot index into the reorder buffer
  typedef logic [`TILE_ROB_W-1:0] rob_id_t;

  // ----------------------------------------------------------------------
  // Dispatch to lanes
  // ----------------------------------------------------------------------
  // Lane select is one-hot, operands already resolved
  typedef struct packed {
    logic                    valid;
    logic [`TILE_ALU_NUM-1:0] lane;
    rob_id_t                 rob_id;
    logic [`TILE_REG_W-1:0]  rd;
    tile_inst_pkg::op_e      op;
    logic [`TILE_XLEN-1:0]   opnd_a;
    logic [`TILE_XLEN-1:0]   opnd_b;
  } disp_t;

  // ----------------------------------------------------------------------
  // Lanes to reorder buffer
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic                  valid;
    rob_id_t               rob_id;
    logic [`TILE_XLEN-1:0] result;
  } done_rpt_t;

  // ----------------------------------------------------------------------
  // Retirement record
  // ----------------------------------------------------------------------
  // Also drives the register file write and scoreboard release
  typedef struct packed {
    logic                   valid;
    rob_id_t                rob_id;
    logic [`TILE_REG_W-1:0] rd;
    logic [`TILE_XLEN-1:0]  value;
  } commit_t;

endpackage

`default_nettype wire

/* verilog/tile_regfile.sv */
`default_nettype none

`include "tile_defines.svh"

module tile_regfile (
  input  logic                   i_clk,
  input  logic                   i_rst,

  input  logic [`TILE_REG_W-1:0] i_rd_addr_a,
  input  logic [`TILE_REG_W-1:0] i_rd_addr_b,
  output logic [`TILE_XLEN-1:0]  o_rd_data_a,
  output logic [`TILE_XLEN-1:0]  o_rd_data_b,

  // Write port driven by retirement
  input  tile_pipe_pkg::commit_t i_commit
);

  logic [`TILE_XLEN-1:0] r_regs [`TILE_NREG];

  // Asynchronous reads
  assign o_rd_data_a = r_regs[i_rd_addr_a];
  assign o_rd_data_b = r_regs[i_rd_addr_b];

  // r0 is cleared at reset and never written, so it reads zero
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 0; i < `TILE_NREG; i++) begin
        r_regs[i] <= '0;
      end
    end else if (i_commit.valid && (i_commit.rd != '0)) begin
      r_regs[i_commit.rd] <= i_commit.value;
    end
  end

endmodule

`default_nettype wire

/* verilog/tile_alu.sv */
`default_nettype none

`include "tile_defines.svh"

module tile_alu #(
  parameter int LANE = 0
) (
  input  logic                     i_clk,
  input  logic                     i_rst,

  input  tile_pipe_pkg::disp_t     i_disp,
  output logic                     o_busy,
  output tile_pipe_pkg::done_rpt_t o_done
);

  import tile_inst_pkg::*;
  import tile_pipe_pkg::*;

  logic                       w_capture;
  logic                       r_busy;
  logic [`TILE_MUL_CNT_W-1:0] r_cnt;
  op_e                        r_op;
  rob_id_t                    r_rob_id;
  logic [`TILE_XLEN-1:0]      r_a;
  logic [`TILE_XLEN-1:0]      r_b;
  logic [`TILE_XLEN-1:0]      r_acc;

  assign w_capture = i_disp.valid && i_disp.lane[LANE];
  assign o_busy    = r_busy;

  // ----------------------------------------------------------------------
  // Control
  // ----------------------------------------------------------------------
  // Short ops take one compute step, a multiply one step per bit
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      r_busy       <= 1'b0;
      r_cnt        <= '0;
      o_done.valid <= 1'b0;
    end else begin
      o_done.valid <= r_busy && (r_cnt == '0);
      if (w_capture) begin
        r_busy <= 1'b1;
        r_cnt  <= (i_disp.op == OP_MUL) ? `TILE_MUL_CNT_W'(`TILE_MUL_CYCLES) :
                                         `TILE_MUL_CNT_W'(1);
      end else if (r_busy) begin
        if (r_cnt == '0) begin
          r_busy <= 1'b0;
        end else begin
          r_cnt <= r_cnt - 1'b1;
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // Datapath
  // ----------------------------------------------------------------------
  always_ff @(posedge i_clk) begin
    if (w_capture) begin
      r_op     <= i_disp.op;
      r_rob_id <= i_disp.rob_id;
      r_a      <= i_disp.opnd_a;
      r_b      <= i_disp.opnd_b;
      r_acc    <= '0;
    end else if (r_busy && (r_cnt != '0)) begin
      case (r_op)
        OP_ADD:  r_acc <= r_a + r_b;
        OP_SUB:  r_acc <= r_a - r_b;
        OP_AND:  r_acc <= r_a & r_b;
        OP_OR:   r_acc <= r_a | r_b;
        OP_XOR:  r_acc <= r_a ^ r_b;
        default: begin
          // Shift-add step, low word only
          r_acc <= r_b[0] ? (r_acc + r_a) : r_acc;
          r_a   <= r_a << 1;
          r_b   <= r_b >> 1;
        end
      endcase
    end
    if (r_busy && (r_cnt == '0)) begin
      o_done.rob_id <= r_rob_id;
      o_done.result <= r_acc;
    end
  end

endmodule

`default_nettype wire

/* verilog/tile_dispatch.sv */
`default_nettype none

`include "tile_defines.svh"

module tile_dispatch (
  input  logic                    i_clk,
  input  logic                    i_rst,

  // Instruction input
  input  tile_inst_pkg::inst_t    i_inst,
  input  logic                    i_inst_valid,
  output logic                    o_inst_ready,

  // Register file read
  output logic [`TILE_REG_W-1:0]  o_rd_addr_a,
  output logic [`TILE_REG_W-1:0]  o_rd_addr_b,
  input  logic [`TILE_XLEN-1:0]   i_rd_data_a,
  input  logic [`TILE_XLEN-1:0]   i_rd_data_b,

  // Lane status and reorder buffer allocation
  input  logic [`TILE_ALU_NUM-1:0] i_lane_busy,
  input  logic                    i_rob_full,
  input  tile_pipe_pkg::rob_id_t  i_rob_tail,
  output logic                    o_alloc_valid,
  output logic [`TILE_REG_W-1:0]  o_alloc_rd,

  output tile_pipe_pkg::disp_t    o_disp,
  input  tile_pipe_pkg::commit_t  i_commit
);

  logic [`TILE_NREG-1:0]    r_pending;
  logic [`TILE_ALU_NUM-1:0] w_targeted;
  logic [`TILE_ALU_NUM-1:0] w_lane_free;
  logic [`TILE_ALU_NUM-1:0] w_lane_pick;
  logic                     w_hazard;
  logic                     w_accept;
  logic [`TILE_XLEN-1:0]    w_opnd_b;

  assign o_rd_addr_a = i_inst.rs1;
  assign o_rd_addr_b = i_inst.operand.r.rs2;

  // Immediate is sign-extended to the full width
  assign w_opnd_b = i_inst.imm_sel ?
                    {{(`TILE_XLEN-`TILE_IMM_W){i_inst.operand.imm[`TILE_IMM_W-1]}},
                     i_inst.operand.imm} :
                    i_rd_data_b;

  // rs2 only counts when the operand is a register
  assign w_hazard = r_pending[i_inst.rs1] ||
                    (!i_inst.imm_sel && r_pending[i_inst.operand.r.rs2]) ||
                    r_pending[i_inst.rd];

  // Lane issued last cycle is not busy yet
  assign w_targeted  = o_disp.valid ? o_disp.lane : '0;
  assign w_lane_free = ~i_lane_busy & ~w_targeted;
  assign w_lane_pick = w_lane_free & (-w_lane_free);

  assign o_inst_ready  = !i_rob_full && (|w_lane_free) && !w_hazard;
  assign w_accept      = i_inst_valid && o_inst_ready;
  assign o_alloc_valid = w_accept;
  assign o_alloc_rd    = i_inst.rd;

  // Pending-write scoreboard, r0 is never tracked
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      r_pending <= '0;
    end else begin
      if (i_commit.valid) begin
        r_pending[i_commit.rd] <= 1'b0;
      end
      if (w_accept && (i_inst.rd != '0)) begin
        r_pending[i_inst.rd] <= 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_disp.valid <= 1'b0;
      o_disp.lane  <= '0;
    end else begin
      o_disp.valid <= w_accept;
      o_disp.lane  <= w_accept ? w_lane_pick : '0;
    end
    if (w_accept) begin
      o_disp.rob_id <= i_rob_tail;
      o_disp.rd     <= i_inst.rd;
      o_disp.op     <= i_inst.op;
      o_disp.opnd_a <= i_rd_data_a;
      o_disp.opnd_b <= w_opnd_b;
    end
  end

endmodule

`default_nettype wire

/* verilog/tile_rob.sv */
`default_nettype none

`include "tile_defines.svh"

module tile_rob (
  input  logic                     i_clk,
  input  logic                     i_rst,

  // Allocation from dispatch
  input  logic                     i_alloc_valid,
  input  logic [`TILE_REG_W-1:0]   i_alloc_rd,
  output tile_pipe_pkg::rob_id_t   o_tail,
  output logic                     o_full,

  // Completions from every lane
  input  tile_pipe_pkg::done_rpt_t i_done [`TILE_ALU_NUM],

  output tile_pipe_pkg::commit_t   o_commit
);

  import tile_pipe_pkg::*;

  logic [`TILE_REG_W-1:0]    r_rd     [`TILE_ROB_SIZE];
  logic [`TILE_XLEN-1:0]     r_result [`TILE_ROB_SIZE];
  logic [`TILE_ROB_SIZE-1:0] r_done;
  rob_id_t                   r_head;
  rob_id_t                   r_tail;
  logic [`TILE_ROB_CNT_W-1:0] r_count;
  logic                      w_head_done;
  logic [`TILE_XLEN-1:0]     w_head_result;
  logic                      w_retire;

  assign o_tail = r_tail;
  assign o_full = (r_count == `TILE_ROB_CNT_W'(`TILE_ROB_SIZE));

  // Head may finish this very cycle, take the report directly
  always_comb begin
    w_head_done   = r_done[r_head];
    w_head_result = r_result[r_head];
    for (int l = 0; l < `TILE_ALU_NUM; l++) begin
      if (i_done[l].valid && (i_done[l].rob_id == r_head)) begin
        w_head_done   = 1'b1;
        w_head_result = i_done[l].result;
      end
    end
  end

  assign w_retire = w_head_done && (r_count != '0);

  // Pointers, occupancy and done flags
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      r_head         <= '0;
      r_tail         <= '0;
      r_count        <= '0;
      r_done         <= '0;
      o_commit.valid <= 1'b0;
    end else begin
      for (int l = 0; l < `TILE_ALU_NUM; l++) begin
        if (i_done[l].valid) begin
          r_done[i_done[l].rob_id] <= 1'b1;
        end
      end
      if (w_retire) begin
        r_done[r_head] <= 1'b0;
        r_head         <= r_head + 1'b1;
      end
      if (i_alloc_valid) begin
        r_done[r_tail] <= 1'b0;
        r_tail         <= r_tail + 1'b1;
      end
      r_count        <= r_count + i_alloc_valid - w_retire;
      o_commit.valid <= w_retire;
    end
  end

  // Entry payload and the retired record
  always_ff @(posedge i_clk) begin
    for (int l = 0; l < `TILE_ALU_NUM; l++) begin
      if (i_done[l].valid) begin
        r_result[i_done[l].rob_id] <= i_done[l].result;
      end
    end
    if (i_alloc_valid) begin
      r_rd[r_tail] <= i_alloc_rd;
    end
    if (w_retire) begin
      o_commit.rob_id <= r_head;
      o_commit.rd     <= r_rd[r_head];
      o_commit.value  <= w_head_result;
    end
  end

endmodule

`default_nettype wire

/* verilog/tile_top.sv */
`default_nettype none

`include "tile_defines.svh"

module tile_top (
  input  logic                   i_clk,
  input  logic                   i_rst,

  input  tile_inst_pkg::inst_t   i_inst,
  input  logic                   i_inst_valid,
  output logic                   o_inst_ready,

  output tile_pipe_pkg::commit_t o_commit
);

  import tile_pipe_pkg::*;

  logic [`TILE_REG_W-1:0]   w_rd_addr_a;
  logic [`TILE_REG_W-1:0]   w_rd_addr_b;
  logic [`TILE_XLEN-1:0]    w_rd_data_a;
  logic [`TILE_XLEN-1:0]    w_rd_data_b;
  logic [`TILE_ALU_NUM-1:0] w_lane_busy;
  logic                     w_rob_full;
  rob_id_t                  w_rob_tail;
  logic                     w_alloc_valid;
  logic [`TILE_REG_W-1:0]   w_alloc_rd;
  disp_t                    w_disp;
  done_rpt_t                w_done [`TILE_ALU_NUM];
  commit_t                  w_commit;

  assign o_commit = w_commit;

  // ----------------------------------------------------------------------
  // Dispatch and register file
  // ----------------------------------------------------------------------
  tile_dispatch u_dispatch (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_inst        (i_inst),
    .i_inst_valid  (i_inst_valid),
    .o_inst_ready  (o_inst_ready),
    .o_rd_addr_a   (w_rd_addr_a),
    .o_rd_addr_b   (w_rd_addr_b),
    .i_rd_data_a   (w_rd_data_a),
    .i_rd_data_b   (w_rd_data_b),
    .i_lane_busy   (w_lane_busy),
    .i_rob_full    (w_rob_full),
    .i_rob_tail    (w_rob_tail),
    .o_alloc_valid (w_alloc_valid),
    .o_alloc_rd    (w_alloc_rd),
    .o_disp        (w_disp),
    .i_commit      (w_commit)
  );

  tile_regfile u_regfile (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_rd_addr_a (w_rd_addr_a),
    .i_rd_addr_b (w_rd_addr_b),
    .o_rd_data_a (w_rd_data_a),
    .o_rd_data_b (w_rd_data_b),
    .i_commit    (w_commit)
  );

  // ----------------------------------------------------------------------
  // Execution lanes
  // ----------------------------------------------------------------------
  generate
    for (genvar alu_idx = 0; alu_idx < `TILE_ALU_NUM; alu_idx++) begin : alu_loop
      tile_alu #(
        .LANE (alu_idx)
      ) u_alu (
        .i_clk  (i_clk),
        .i_rst  (i_rst),
        .i_disp (w_disp),
        .o_busy (w_lane_busy[alu_idx]),
        .o_done (w_done[alu_idx])
      );
    end
  endgenerate

  // In-order retirement
  tile_rob u_rob (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_alloc_valid (w_alloc_valid),
    .i_alloc_rd    (w_alloc_rd),
    .o_tail        (w_rob_tail),
    .o_full        (w_rob_full),
    .i_done        (w_done),
    .o_commit      (w_commit)
  );

endmodule

`default_nettype wire

/* bench/tile_tb.sv */
`default_nettype none

`include "tile_defines.svh"

module tile_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import tile_inst_pkg::*;
  import tile_pipe_pkg::*;

  typedef logic [`TILE_REG_W-1:0] reg_idx_t;
  typedef logic [`TILE_XLEN-1:0]  word_t;

  localparam int N_INST          = 400;
  localparam int WATCHDOG_CYCLES = N_INST * (`TILE_MUL_CYCLES + 8);

  logic    clk = 1'b0;
  logic    rst;
  inst_t   inst;
  logic    inst_valid;
  logic    inst_ready;
  commit_t commit;

  // Reference model state
  word_t    mregs [`TILE_NREG];
  inst_t    pend_q [$];
  int       acc_cnt     = 0;
  int       com_cnt     = 0;
  int       outstanding = 0;
  int       cyc         = 0;
  int       full_hits   = 0;
  logic     exp_valid   = 1'b0;
  rob_id_t  exp_rob_id  = '0;
  reg_idx_t exp_rd      = '0;
  word_t    exp_value   = '0;
  int       err_order   = 0;
  int       err_value   = 0;
  int       err_flow    = 0;

  // Stimulus state
  reg_idx_t prev_rd    = '0;
  int       burst_left = 0;

  tile_top i_tile_top (
    .i_clk        (clk),
    .i_rst        (rst),
    .i_inst       (inst),
    .i_inst_valid (inst_valid),
    .o_inst_ready (inst_ready),
    .o_commit     (commit)
  );

  always #2 clk = ~clk;

  // ----------------------------------------------------------------------
  // Reference model and stimulus helpers
  // ----------------------------------------------------------------------
  // Result from the architectural state left by all older commits
  function automatic word_t model_result(input inst_t ins);
    word_t a;
    word_t b;
    a = mregs[ins.rs1];
    if (ins.imm_sel) begin
      b = {{(`TILE_XLEN-`TILE_IMM_W){ins.operand.imm[`TILE_IMM_W-1]}}, ins.operand.imm};
    end else begin
      b = mregs[ins.operand.r.rs2];
    end
    case (ins.op)
      OP_ADD:  return a + b;
      OP_SUB:  return a - b;
      OP_AND:  return a & b;
      OP_OR:   return a | b;
      OP_XOR:  return a ^ b;
      default: return a * b;
    endcase
  endfunction

  task automatic build_inst(output inst_t ins);
    int sel;
    sel         = $urandom_range(0, 99);
    ins.op      = op_e'(3'($urandom_range(0, 4)));
    ins.imm_sel = 1'($urandom_range(0, 1));
    ins.rd      = ($urandom_range(0, 9) == 0) ? '0 : reg_idx_t'($urandom_range(1, 15));
    ins.rs1     = reg_idx_t'($urandom);
    ins.operand.imm = 12'($urandom);
    if (burst_left > 0) begin
      // Short ops behind a multiply with distinct rd and no register sources
      ins.rd      = reg_idx_t'(15 - burst_left);
      ins.rs1     = '0;
      ins.imm_sel = 1'b1;
      burst_left--;
    end else if (sel < 8) begin
      // Long head entry so the reorder buffer fills up behind it
      ins.op     = OP_MUL;
      ins.rd     = reg_idx_t'($urandom_range(1, 7));
      burst_left = 7;
    end else if (sel < 16) begin
      ins.op = OP_MUL;
    end else if (sel < 50) begin
      ins.rs1 = prev_rd;
    end
    prev_rd = ins.rd;
  endtask

  // Holds the offer from a falling edge until the transfer
  task automatic send_inst(input inst_t ins);
    int target;
    target     = acc_cnt + 1;
    inst       = ins;
    inst_valid = 1'b1;
    while (acc_cnt != target) begin
      @(negedge clk);
    end
  endtask

  // ----------------------------------------------------------------------
  // Monitor
  // ----------------------------------------------------------------------
  always @(posedge clk) begin
    inst_t head;
    int    acc_next;
    int    com_next;
    acc_next = acc_cnt;
    com_next = com_cnt;
    if (!rst) begin
      if (outstanding == `TILE_ROB_SIZE && !commit.valid) begin
        full_hits++;
      end
      if (commit.valid) begin
        com_next++;
        if (pend_q.size() != 0) begin
          head = pend_q.pop_front();
          if (head.rd != '0) begin
            mregs[head.rd] = model_result(head);
          end
        end
      end
      if (inst_valid && inst_ready) begin
        pend_q.push_back(inst);
        acc_next++;
      end
    end
    // Expectation for the next commit
    exp_valid <= (pend_q.size() != 0);
    if (pend_q.size() != 0) begin
      head = pend_q[0];
      exp_rd    <= head.rd;
      exp_value <= model_result(head);
    end
    exp_rob_id  <= rob_id_t'(com_next);
    acc_cnt     <= acc_next;
    com_cnt     <= com_next;
    outstanding <= acc_next - com_next;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------
  reset_quiet_chk: assert property (@(posedge clk) (cyc >= 1 && cyc <= 4) |-> !commit.valid)
    else begin
      err_flow++;
      $display("Error at %0d ns: commit seen during reset", $time);
    end

  commit_order_chk: assert property (@(posedge clk) disable iff (rst)
    commit.valid |-> (exp_valid && commit.rob_id == exp_rob_id && commit.rd == exp_rd))
    else begin
      err_order++;
      $display("Error at %0d ns: commit rob_id %0d rd %0d, expected rob_id %0d rd %0d",
               $time, $sampled(commit.rob_id), $sampled(commit.rd),
               $sampled(exp_rob_id), $sampled(exp_rd));
    end

  // Also covers reads of r0, which the model holds at zero
  commit_value_chk: assert property (@(posedge clk) disable iff (rst)
    (commit.valid && exp_valid) |-> (commit.value == exp_value))
    else begin
      err_value++;
      $display("Error at %0d ns: commit value %h, expected %h",
               $time, $sampled(commit.value), $sampled(exp_value));
    end

  window_chk: assert property (@(posedge clk) disable iff (rst)
    outstanding <= `TILE_ROB_SIZE)
    else begin
      err_flow++;
      $display("Error at %0d ns: %0d instructions in flight", $time, $sampled(outstanding));
    end

  full_stall_chk: assert property (@(posedge clk) disable iff (rst)
    (outstanding == `TILE_ROB_SIZE && !commit.valid) |-> !inst_ready)
    else begin
      err_flow++;
      $display("Error at %0d ns: ready high with a full reorder buffer", $time);
    end

  empty_commit_chk: assert property (@(posedge clk) disable iff (rst)
    commit.valid |-> (outstanding != 0))
    else begin
      err_flow++;
      $display("Error at %0d ns: commit with nothing outstanding", $time);
    end

  // ----------------------------------------------------------------------
  // Stimulus and end of run
  // ----------------------------------------------------------------------
  initial begin
    inst_t ins;
    void'($urandom(32'h25d9_3ef5));
    rst        = 1'b1;
    inst       = '0;
    inst_valid = 1'b0;
    for (int r = 0; r < `TILE_NREG; r++) begin
      mregs[r] = '0;
    end
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int n = 0; n < N_INST; n++) begin
      build_inst(ins);
      send_inst(ins);
      if ($urandom_range(0, 9) == 0) begin
        inst_valid = 1'b0;
        repeat ($urandom_range(1, 3)) @(negedge clk);
      end
    end
    inst_valid = 1'b0;
    while (com_cnt < N_INST) begin
      @(negedge clk);
    end
    repeat (8) @(negedge clk);
    commit_count_chk: assert (com_cnt == N_INST)
      else begin
        err_flow++;
        $display("Count mismatch: %0d committed of %0d sent", com_cnt, N_INST);
      end
    rob_fill_chk: assert (full_hits != 0)
      else begin
        err_flow++;
        $display("The reorder buffer never filled during the run");
      end
    $display("Result: %0d order errors, %0d value errors, %0d flow errors, %0d commits",
             err_order, err_value, err_flow, com_cnt);
    if (err_order + err_value + err_flow == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("The run timed out after %0d cycles with %0d of %0d instructions committed",
             WATCHDOG_CYCLES, com_cnt, N_INST);
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
+incdir+verilog
verilog/tile_inst_pkg.sv
verilog/tile_pipe_pkg.sv
verilog/tile_regfile.sv
verilog/tile_alu.sv
verilog/tile_dispatch.sv
verilog/tile_rob.sv
verilog/tile_top.sv
bench/tile_tb.sv

/* Makefile */
TOOL      := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := tile_tb
FILELIST  := src.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "^TEST PASSED$$" $(LOG); then \
		echo "Simulation log shows a pass"; \
	else \
		echo "Simulation log shows no pass"; \
		exit 1; \
	fi

lint:
	$(TOOL) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
